// ==== exeDefs.svh ====
/* widths, ALU control codes and opcode values
   shared by the execute stage */
`default_nettype none

`ifndef EXE_DEFS_SVH
`define EXE_DEFS_SVH

// widths
`define EXE_WORD_WIDTH      32
`define EXE_REG_WIDTH       6
`define EXE_ROB_WIDTH       6
`define EXE_SHAMT_WIDTH     5
`define EXE_ALU_CTRL_WIDTH  6

// --------------------
// ALU control codes
`define ALU_ADD   6'd0
`define ALU_SUB   6'd1
`define ALU_AND   6'd2
`define ALU_OR    6'd3
`define ALU_XOR   6'd4
`define ALU_NOR   6'd5
`define ALU_SLT   6'd6
`define ALU_SLTU  6'd7
`define ALU_SLL   6'd8
`define ALU_SRL   6'd9
`define ALU_SRA   6'd10
`define ALU_LUI   6'd11

// --------------------
// opcode field [31:26], regimm selector in rt [20:16]
`define OP_REGIMM 6'b000001
`define OP_J      6'b000010
`define OP_JAL    6'b000011
`define OP_BEQ    6'b000100
`define OP_BNE    6'b000101
`define OP_BLEZ   6'b000110
`define OP_BGTZ   6'b000111
`define RT_BLTZ   5'b00000
`define RT_BGEZ   5'b00001

`endif

`default_nettype wire

// ==== exePkg.sv ====
/* execute stage types
   data word, register tag, ROB pointer, ALU control, shift amount, instruction */
`include "exeDefs.svh"
`default_nettype none

package exePkg;

   // one data word, also used for pc and targets
   typedef logic [`EXE_WORD_WIDTH-1:0] word_t;

   // architectural register tag
   typedef logic [`EXE_REG_WIDTH-1:0] regAddr_t;

   // reorder buffer entry
   typedef logic [`EXE_ROB_WIDTH-1:0] robPtr_t;

   // selects the ALU operation
   typedef logic [`EXE_ALU_CTRL_WIDTH-1:0] aluCtrl_t;

   // shift amount from the instruction
   typedef logic [`EXE_SHAMT_WIDTH-1:0] shamt_t;

   // raw instruction word
   typedef logic [`EXE_WORD_WIDTH-1:0] instr_t;

endpackage

`default_nettype wire

// ==== fwdIf.sv ====
/* forwarding bus between the stage top and the operand selector */
`timescale 1ns/100ps
`default_nettype none

interface fwdIf import exePkg::*; ();

   // stage's own registered result
   logic     exeRegWrite;
   logic     exeMemRead;
   regAddr_t exeReg;
   word_t    exeResult;

   // commit side, ALU then load data
   logic     comValid;
   regAddr_t comReg;
   word_t    comData;
   logic     lsValid;
   regAddr_t lsReg;
   word_t    lsData;

   // current instruction
   regAddr_t srcRegA;
   regAddr_t srcRegB;
   word_t    regOperandA;
   word_t    regOperandB;
   word_t    immediate;
   logic     aluSrc;

   // selected operands
   word_t    operandA;
   word_t    operandB;
   logic     hazard;

   modport source (
      output exeRegWrite, exeMemRead, exeReg, exeResult,
      output comValid, comReg, comData, lsValid, lsReg, lsData,
      output srcRegA, srcRegB, regOperandA, regOperandB, immediate, aluSrc,
      input  operandA, operandB, hazard
   );

   modport forward (
      input  exeRegWrite, exeMemRead, exeReg, exeResult,
      input  comValid, comReg, comData, lsValid, lsReg, lsData,
      input  srcRegA, srcRegB, regOperandA, regOperandB, immediate, aluSrc,
      output operandA, operandB, hazard
   );

endinterface

`default_nettype wire

// ==== operandForward.sv ====
/* operand forwarding mux with load-use hazard detection */
`timescale 1ns/100ps
`default_nettype none

module operandForward import exePkg::*; (
   fwdIf.forward fwd
);

   logic hazardA;
   logic hazardB;

   // --------------------
   // priority: own result, load in flight, commit ALU, commit load, register file
   function automatic word_t fwdValue(input regAddr_t src, input word_t regVal);
      if (fwd.exeRegWrite && (fwd.exeReg == src)) begin
         return fwd.exeResult;
      end else if (fwd.exeMemRead && (fwd.exeReg == src)) begin
         // load not back yet, hazard flags this
         return regVal;
      end else if (fwd.comValid && (fwd.comReg == src)) begin
         return fwd.comData;
      end else if (fwd.lsValid && (fwd.lsReg == src)) begin
         return fwd.lsData;
      end else begin
         return regVal;
      end
   endfunction

   // load-use only counts when the own ALU result does not already match
   function automatic logic loadUse(input regAddr_t src);
      logic tagHit;
      tagHit = (fwd.exeReg == src);
      return fwd.exeMemRead && tagHit && !(fwd.exeRegWrite && tagHit);
   endfunction

   // --------------------
   assign hazardA = loadUse(fwd.srcRegA);

   // immediate operand never waits on a load
   assign hazardB = !fwd.aluSrc && loadUse(fwd.srcRegB);

   assign fwd.operandA = fwdValue(fwd.srcRegA, fwd.regOperandA);
   assign fwd.operandB = fwd.aluSrc ? fwd.immediate
                                    : fwdValue(fwd.srcRegB, fwd.regOperandB);

   assign fwd.hazard = hazardA || hazardB;

endmodule

`default_nettype wire

// ==== aluCore.sv ====
/* combinational integer ALU
   add, sub, logic ops, set-less-than, shifts and lui */
`include "exeDefs.svh"
`timescale 1ns/100ps
`default_nettype none

module aluCore import exePkg::*; (
   input  word_t    opA,
   input  word_t    opB,
   input  aluCtrl_t aluCtrl,
   input  shamt_t   shamt,
   output word_t    result
);

   logic ltSigned;
   logic ltUnsigned;

   assign ltSigned   = ($signed(opA) < $signed(opB));
   assign ltUnsigned = (opA < opB);

   always_comb begin
      case (aluCtrl)
         `ALU_ADD:  result = opA + opB;
         `ALU_SUB:  result = opA - opB;
         `ALU_AND:  result = opA & opB;
         `ALU_OR:   result = opA | opB;
         `ALU_XOR:  result = opA ^ opB;
         `ALU_NOR:  result = ~(opA | opB);

         // compare results are a single 0 or 1
         `ALU_SLT:  result = word_t'(ltSigned);
         `ALU_SLTU: result = word_t'(ltUnsigned);

         // shifts act on rt, which is operand B
         `ALU_SLL:  result = opB << shamt;
         `ALU_SRL:  result = opB >> shamt;
         `ALU_SRA:  result = word_t'($signed(opB) >>> shamt);

         // immediate into the upper half
         `ALU_LUI:  result = opB << 16;

         default:   result = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== branchUnit.sv ====
/* branch condition compare and branch/jump target generation */
`include "exeDefs.svh"
`timescale 1ns/100ps
`default_nettype none

module branchUnit import exePkg::*; (
   input  instr_t instr,
   input  word_t  pc,
   input  word_t  immediate,
   input  word_t  opA,
   input  word_t  opB,
   input  logic   branch,
   input  logic   jump,
   output logic   taken,
   output word_t  targetPc
);

   logic [5:0] opcode;
   logic [4:0] rtSel;
   logic       condMet;
   logic       opAZero;
   word_t      jumpTarget;
   word_t      branchTarget;

   assign opcode  = instr[31:26];
   assign rtSel   = instr[20:16];
   assign opAZero = (opA == '0);

   // --------------------
   // condition decode, sign tests use opA[31]
   always_comb begin
      case (opcode)
         `OP_BEQ:  condMet = (opA == opB);
         `OP_BNE:  condMet = (opA != opB);
         `OP_BLEZ: condMet = opA[31] || opAZero;
         `OP_BGTZ: condMet = !opA[31] && !opAZero;
         `OP_REGIMM: begin
            case (rtSel)
               `RT_BLTZ: condMet = opA[31];
               `RT_BGEZ: condMet = !opA[31];
               default:  condMet = 1'b0;
            endcase
         end
         `OP_J, `OP_JAL: condMet = 1'b1;
         default:  condMet = 1'b0;
      endcase
   end

   // --------------------
   // dedicated target adder, ALU stays on operands
   assign jumpTarget   = {pc[31:28], instr[25:0], 2'b00};
   assign branchTarget = pc + (immediate << 2);

   assign taken    = branch ? condMet : jump;
   assign targetPc = jump   ? jumpTarget
                   : branch ? branchTarget
                   : '0;

endmodule

`default_nettype wire

// ==== exePipeReg.sv ====
/* execute stage output register
   freezable, squashes control bits of a load-use hazard */
`timescale 1ns/100ps
`default_nettype none

module exePipeReg import exePkg::*; (
   input  logic     CLK,
   input  logic     RESET,
   input  logic     freeze,
   input  logic     validIn,
   input  logic     hazard,
   input  robPtr_t  robPtrIn,
   input  regAddr_t destRegIn,
   input  logic     regWriteIn,
   input  logic     memReadIn,
   input  word_t    aluResultIn,
   input  logic     takenIn,
   input  word_t    targetPcIn,
   input  word_t    pcIn,
   output robPtr_t  robPtrOut,
   output regAddr_t destRegOut,
   output logic     regWriteOut,
   output logic     memReadOut,
   output word_t    aluResultOut,
   output logic     branchTakenOut,
   output word_t    targetPcOut,
   output word_t    pcOut,
   output logic     validOut,
   output logic     hazardOut
);

   // instruction survives only without a load-use hazard
   logic keep;

   assign keep = !hazard;

   always_ff @(posedge CLK or negedge RESET) begin
      if (!RESET) begin
         robPtrOut      <= '0;
         destRegOut     <= '0;
         regWriteOut    <= 1'b0;
         memReadOut     <= 1'b0;
         aluResultOut   <= '0;
         branchTakenOut <= 1'b0;
         targetPcOut    <= '0;
         pcOut          <= '0;
         validOut       <= 1'b0;
         hazardOut      <= 1'b0;
      end else if (!freeze) begin
         robPtrOut      <= robPtrIn;
         destRegOut     <= destRegIn;
         aluResultOut   <= aluResultIn;
         targetPcOut    <= targetPcIn;
         pcOut          <= pcIn;
         // cleared so a squashed op cannot forward itself next cycle
         regWriteOut    <= regWriteIn && keep;
         memReadOut     <= memReadIn && keep;
         branchTakenOut <= takenIn && keep;
         validOut       <= validIn && keep;
         hazardOut      <= hazard;
      end
   end

endmodule

`default_nettype wire

// ==== exeStage.sv ====
/* execute stage top
   forwarding, ALU, branch unit and output register */
`timescale 1ns/100ps
`default_nettype none

module exeStage import exePkg::*; (
   input  logic     CLK,
   input  logic     RESET,
   input  logic     freeze,
   // instruction
   input  logic     validIn,
   input  robPtr_t  robPtrIn,
   input  word_t    pcIn,
   input  instr_t   instrIn,
   input  regAddr_t destRegIn,
   input  regAddr_t srcRegA,
   input  regAddr_t srcRegB,
   input  word_t    regOperandA,
   input  word_t    regOperandB,
   input  word_t    immediate,
   // decoded control
   input  aluCtrl_t aluCtrl,
   input  shamt_t   shamt,
   input  logic     aluSrc,
   input  logic     regWrite,
   input  logic     memRead,
   input  logic     branch,
   input  logic     jump,
   // commit forwarding
   input  logic     comValid,
   input  regAddr_t comReg,
   input  word_t    comData,
   input  logic     lsValid,
   input  regAddr_t lsReg,
   input  word_t    lsData,
   // registered results
   output robPtr_t  robPtrOut,
   output regAddr_t destRegOut,
   output logic     regWriteOut,
   output logic     memReadOut,
   output word_t    aluResultOut,
   output logic     branchTakenOut,
   output word_t    targetPcOut,
   output word_t    pcOut,
   output logic     validOut,
   output logic     hazardOut
);

   word_t aluResult;
   logic  taken;
   word_t targetPc;

   fwdIf fwdBus ();

   // --------------------
   // own output register feeds back as the nearest source
   assign fwdBus.exeRegWrite = regWriteOut;
   assign fwdBus.exeMemRead  = memReadOut;
   assign fwdBus.exeReg      = destRegOut;
   assign fwdBus.exeResult   = aluResultOut;

   assign fwdBus.comValid    = comValid;
   assign fwdBus.comReg      = comReg;
   assign fwdBus.comData     = comData;
   assign fwdBus.lsValid     = lsValid;
   assign fwdBus.lsReg       = lsReg;
   assign fwdBus.lsData      = lsData;

   assign fwdBus.srcRegA     = srcRegA;
   assign fwdBus.srcRegB     = srcRegB;
   assign fwdBus.regOperandA = regOperandA;
   assign fwdBus.regOperandB = regOperandB;
   assign fwdBus.immediate   = immediate;
   assign fwdBus.aluSrc      = aluSrc;

   // --------------------
   operandForward u_fwd (
      .fwd (fwdBus.forward)
   );

   aluCore u_alu (
      .opA     (fwdBus.operandA),
      .opB     (fwdBus.operandB),
      .aluCtrl (aluCtrl),
      .shamt   (shamt),
      .result  (aluResult)
   );

   branchUnit u_branch (
      .instr     (instrIn),
      .pc        (pcIn),
      .immediate (immediate),
      .opA       (fwdBus.operandA),
      .opB       (fwdBus.operandB),
      .branch    (branch),
      .jump      (jump),
      .taken     (taken),
      .targetPc  (targetPc)
   );

   exePipeReg u_preg (
      .CLK            (CLK),
      .RESET          (RESET),
      .freeze         (freeze),
      .validIn        (validIn),
      .hazard         (fwdBus.hazard),
      .robPtrIn       (robPtrIn),
      .destRegIn      (destRegIn),
      .regWriteIn     (regWrite),
      .memReadIn      (memRead),
      .aluResultIn    (aluResult),
      .takenIn        (taken),
      .targetPcIn     (targetPc),
      .pcIn           (pcIn),
      .robPtrOut      (robPtrOut),
      .destRegOut     (destRegOut),
      .regWriteOut    (regWriteOut),
      .memReadOut     (memReadOut),
      .aluResultOut   (aluResultOut),
      .branchTakenOut (branchTakenOut),
      .targetPcOut    (targetPcOut),
      .pcOut          (pcOut),
      .validOut       (validOut),
      .hazardOut      (hazardOut)
   );

endmodule

`default_nettype wire

// ==== exeAssert.sv ====
/* concurrent checks on the execute stage outputs
   bound into exeStage */
`timescale 1ns/100ps
`default_nettype none

module exeAssert import exePkg::*; (
   input logic  CLK,
   input logic  RESET,
   input logic  freeze,
   input logic  validOut,
   input logic  hazardOut,
   input word_t aluResultOut
);

   // number of failed checks
   int failCount = 0;

   // squashed instruction never leaves as valid
   hazardNotValid: assert property (
      @(posedge CLK) disable iff (!RESET) hazardOut |-> !validOut
   ) else begin
      failCount++;
      $error("hazardOut and validOut high together");
   end

   // frozen cycle holds the output register
   freezeHolds: assert property (
      @(posedge CLK) disable iff (!RESET)
         freeze |=> ($stable(aluResultOut) && $stable(validOut))
   ) else begin
      failCount++;
      $error("outputs changed while freeze was high");
   end

   validKnown: assert property (
      @(posedge CLK) disable iff (!RESET) !$isunknown(validOut)
   ) else begin
      failCount++;
      $error("validOut unknown after reset");
   end

endmodule

bind exeStage exeAssert u_assert (
   .CLK          (CLK),
   .RESET        (RESET),
   .freeze       (freeze),
   .validOut     (validOut),
   .hazardOut    (hazardOut),
   .aluResultOut (aluResultOut)
);

`default_nettype wire

// ==== tbExeStage.sv ====
/* execute stage testbench
   vectors from exe_testdata.txt, output checks one cycle later, watchdog */
`timescale 1ns/100ps
`default_nettype none

module tbExeStage import exePkg::*; ();

   localparam int clkPeriod = 40;
   localparam int numFields = 22;
   localparam int maxVecs   = 64;

   logic     CLK = 1'b0;
   logic     RESET = 1'b0;
   logic     freeze = 1'b0;
   logic     validIn = 1'b0;
   robPtr_t  robPtrIn = '0;
   word_t    pcIn = '0;
   instr_t   instrIn = '0;
   regAddr_t destRegIn = '0;
   regAddr_t srcRegA = '0;
   regAddr_t srcRegB = '0;
   word_t    regOperandA = '0;
   word_t    regOperandB = '0;
   word_t    immediate = '0;
   aluCtrl_t aluCtrl = '0;
   shamt_t   shamt = '0;
   logic     aluSrc = 1'b0;
   logic     regWrite = 1'b0;
   logic     memRead = 1'b0;
   logic     branch = 1'b0;
   logic     jump = 1'b0;
   logic     comValid = 1'b0;
   regAddr_t comReg = '0;
   word_t    comData = '0;
   logic     lsValid = 1'b0;
   regAddr_t lsReg = '0;
   word_t    lsData = '0;

   robPtr_t  robPtrOut;
   regAddr_t destRegOut;
   logic     regWriteOut;
   logic     memReadOut;
   word_t    aluResultOut;
   logic     branchTakenOut;
   word_t    targetPcOut;
   word_t    pcOut;
   logic     validOut;
   logic     hazardOut;

   // fields 0..15 stimulus, 16..21 expected
   word_t vecMem [0:numFields*maxVecs-1];
   int    numVecs = 0;
   int    errorCount = 0;

   exeStage u_dut (.*);

   initial begin
      forever #(clkPeriod / 2) CLK = ~CLK;
   end

   // --------------------
   task automatic reportMismatch(input string name, input word_t actual, input word_t expected);
      $display("[ERROR] %0d ns %s expected %h actual %h", $time, name, expected, actual);
      errorCount++;
   endtask

   task automatic applyVector(input int idx);
      int    b;
      word_t flags;
      b = idx * numFields;
      flags = vecMem[b];
      freeze      <= flags[8];
      validIn     <= flags[7];
      aluSrc      <= flags[6];
      regWrite    <= flags[5];
      memRead     <= flags[4];
      branch      <= flags[3];
      jump        <= flags[2];
      comValid    <= flags[1];
      lsValid     <= flags[0];
      robPtrIn    <= robPtr_t'(vecMem[b + 1]);
      pcIn        <= vecMem[b + 2];
      instrIn     <= vecMem[b + 3];
      destRegIn   <= regAddr_t'(vecMem[b + 4]);
      srcRegA     <= regAddr_t'(vecMem[b + 5]);
      srcRegB     <= regAddr_t'(vecMem[b + 6]);
      regOperandA <= vecMem[b + 7];
      regOperandB <= vecMem[b + 8];
      immediate   <= vecMem[b + 9];
      aluCtrl     <= aluCtrl_t'(vecMem[b + 10]);
      shamt       <= shamt_t'(vecMem[b + 11]);
      comReg      <= regAddr_t'(vecMem[b + 12]);
      comData     <= vecMem[b + 13];
      lsReg       <= regAddr_t'(vecMem[b + 14]);
      lsData      <= vecMem[b + 15];
   endtask

   // expected flags: valid hazard regWrite memRead taken
   task automatic compareOutputs(input logic [4:0] eFlags, input robPtr_t eRob,
                                 input regAddr_t eDst, input word_t eAlu,
                                 input word_t eTgt, input word_t ePc);
      if (validOut !== eFlags[4])
         reportMismatch("validOut", word_t'(validOut), word_t'(eFlags[4]));
      if (hazardOut !== eFlags[3])
         reportMismatch("hazardOut", word_t'(hazardOut), word_t'(eFlags[3]));
      if (regWriteOut !== eFlags[2])
         reportMismatch("regWriteOut", word_t'(regWriteOut), word_t'(eFlags[2]));
      if (memReadOut !== eFlags[1])
         reportMismatch("memReadOut", word_t'(memReadOut), word_t'(eFlags[1]));
      if (branchTakenOut !== eFlags[0])
         reportMismatch("branchTakenOut", word_t'(branchTakenOut), word_t'(eFlags[0]));
      if (robPtrOut !== eRob)
         reportMismatch("robPtrOut", word_t'(robPtrOut), word_t'(eRob));
      if (destRegOut !== eDst)
         reportMismatch("destRegOut", word_t'(destRegOut), word_t'(eDst));
      if (aluResultOut !== eAlu)
         reportMismatch("aluResultOut", aluResultOut, eAlu);
      if (targetPcOut !== eTgt)
         reportMismatch("targetPcOut", targetPcOut, eTgt);
      if (pcOut !== ePc)
         reportMismatch("pcOut", pcOut, ePc);
   endtask

   task automatic checkVector(input int idx);
      int b;
      b = idx * numFields + 16;
      compareOutputs(vecMem[b][4:0], robPtr_t'(vecMem[b + 1]), regAddr_t'(vecMem[b + 2]),
                     vecMem[b + 3], vecMem[b + 4], vecMem[b + 5]);
   endtask

   // --------------------
   initial begin
      // unused slots marked dead in the upper half
      for (int a = 0; a < numFields * maxVecs; a++) begin
         vecMem[a] = {16'hdead, a[15:0]};
      end
      $readmemh("exe_testdata.txt", vecMem);
      while (numVecs < maxVecs && vecMem[numVecs * numFields][31:16] != 16'hdead) begin
         numVecs++;
      end
      if (numVecs == 0) begin
         $display("No test vectors were found in exe_testdata.txt");
         errorCount++;
      end

      repeat (4) @(posedge CLK);
      RESET <= 1'b1;
      @(negedge CLK);
      compareOutputs(5'b0, '0, '0, '0, '0, '0);

      @(posedge CLK);
      if (numVecs > 0) begin
         applyVector(0);
      end
      for (int i = 0; i < numVecs; i++) begin
         @(posedge CLK);
         if (i + 1 < numVecs) begin
            applyVector(i + 1);
         end
         @(negedge CLK);
         checkVector(i);
      end

      // failed checks of the bound checker
      errorCount += u_dut.u_assert.failCount;

      $display("Vectors checked: %0d, errors: %0d", numVecs, errorCount);
      if (errorCount == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // watchdog, armed once the vector count is known
   initial begin
      #1;
      #((numVecs + 20) * clkPeriod);
      $display("Watchdog expired before all vectors were checked");
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== exe_testdata.txt ====
// in: flg rob pc instr dst sA sB rA rB imm ctl sh cR cD lR lD | exp: flg rob dst alu tgt pc
// flg in = frz vld aluSrc regWr memRd br jmp comV lsV, flg exp = vld haz regWr memRd taken
// branches taken and not taken, one ALU op each, no forwarding
088 0 100 10000000 0 1 2 5 5 4 0 0 0 0 0 0   11 0 0 a 110 100
088 1 104 10000000 0 1 2 3 5 8 1 0 0 0 0 0   10 1 0 fffffffe 124 104
088 2 108 14000000 0 1 2 f0f0 ff00 fffffffc 2 0 0 0 0 0   11 2 0 f000 f8 108
088 3 10c 14000000 0 1 2 f0f0 f0f0 1 3 0 0 0 0 0   10 3 0 f0f0 110 10c
088 4 110 18000000 0 1 2 0 ff 2 4 0 0 0 0 0   11 4 0 ff 118 110
088 5 114 18000000 0 1 2 5 fffffff0 3 5 0 0 0 0 0   10 5 0 a 120 114
0c8 6 118 1c000000 0 1 2 7 0 4 b 0 0 0 0 0   11 6 0 40000 128 118
088 7 11c 1c000000 0 1 2 0 1 5 8 4 0 0 0 0   10 7 0 10 130 11c
088 8 120 04000000 0 1 2 ffffffff 1 6 6 0 0 0 0 0   11 8 0 1 138 120
088 9 124 04000000 0 1 2 2 80000000 7 9 4 0 0 0 0   10 9 0 8000000 140 124
088 a 128 04010000 0 1 2 0 80000000 8 a 4 0 0 0 0   11 a 0 f8000000 148 128
088 b 12c 04010000 0 1 2 ffffffff 1 9 7 0 0 0 0 0   10 b 0 0 150 12c
084 c 130 08000123 0 1 2 0 0 0 0 0 0 0 0 0   11 c 0 0 48c 130
// forwarding from own result, commit ALU and commit load
0e0 d 134 0 22 23 0 10 0 5 0 0 0 0 0 0   14 d 22 15 0 134
0a2 e 138 0 24 22 25 999 1 0 0 0 22 aaaa 0 0   14 e 24 16 0 138
0a3 f 13c 0 35 30 31 0 3 0 0 0 30 100 30 200   14 f 35 103 0 13c
0a3 10 140 0 36 32 34 7 2 0 0 0 33 999 32 40   14 10 36 42 0 140
// load then dependent add, frozen cycle, same add released
0d0 11 144 0 37 38 0 1000 0 8 0 0 0 0 0 0   12 11 37 1008 0 144
0a0 12 148 0 3a 37 39 5 1 0 0 0 0 0 0 0   08 12 3a 6 0 148
1a0 13 14c 0 3b 3c 3d 20 1 0 0 0 0 0 0 0   08 12 3a 6 0 148
0a0 13 14c 0 3b 3c 3d 20 1 0 0 0 0 0 0 0   14 13 3b 21 0 14c

// ==== list.f ====
+incdir+.
exePkg.sv
fwdIf.sv
operandForward.sv
aluCore.sv
branchUnit.sv
exePipeReg.sv
exeStage.sv
exeAssert.sv
tbExeStage.sv

// ==== Makefile ====
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tbExeStage
FILELIST  ?= list.f
BUILDDIR  ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)
	@out="$$(./$(BUILDDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(BUILDDIR)
